// ==== Makefile ====
TOP = xgmii_rx_mac_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== all.f ====
source/xgmii_rx_pkg.sv
source/crc32_eth_x32_var.sv
source/rx_framer.sv
source/fcs_checker.sv
source/xgmii_rx_mac.sv
bench/xgmii_rx_mac_tb.sv

// ==== bench/xgmii_rx_mac_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module xgmii_rx_mac_tb;

	import xgmii_rx_pkg::*;

	// 64 frames of at most 20 words each plus drains
	// Stalls add about one word in seven
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int KIND_GOOD = 0;
	localparam int KIND_BAD_FCS = 1;
	localparam int KIND_BAD_PRE = 2;
	localparam int KIND_ABORT = 3;
	// Good or bad FCS picked per frame
	localparam int KIND_MIX = 4;

	logic xgmii_rx_clk = 1'b0;
	logic rst_n;
	xgmii_word_u xgmii_rxd;
	logic [3:0] xgmii_rxc;
	logic xgmii_rx_valid;
	logic [31:0] rx_data;
	logic rx_valid;
	logic [3:0] rx_strb;
	logic rx_last;
	logic rx_error;

	// Reference model state
	// Byte stream in order, then one close entry per frame
	logic [7:0] exp_bytes[$];
	logic exp_err[$];
	int exp_cnt[$];
	logic [7:0] payload[$];
	logic [15:0] lfsr = 16'd54009;
	int cycle_count = 0;
	int check_count = 0;
	int error_count = 0;
	int frame_bytes = 0;
	bit stall_en = 1'b0;
	bit junk_en = 1'b0;

	always #4 xgmii_rx_clk = ~xgmii_rx_clk;

	xgmii_rx_mac dut(
		.xgmii_rx_clk(xgmii_rx_clk),
		.rst_n(rst_n),
		.xgmii_rxd(xgmii_rxd),
		.xgmii_rxc(xgmii_rxc),
		.xgmii_rx_valid(xgmii_rx_valid),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_strb(rx_strb),
		.rx_last(rx_last),
		.rx_error(rx_error)
	);

	////////////////////////////////////////////////////////////
	// Random source and FCS

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// 802.3 CRC-32 of the payload
	// Bit 0 of each byte goes out first
	function automatic logic [31:0] payload_fcs();
		logic [31:0] c;
		c = 32'hffff_ffff;
		foreach (payload[i]) begin
			c = c ^ {24'd0, payload[i]};
			for (int k = 0; k < 8; k++) begin
				c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
			end
		end
		return ~c;
	endfunction

	////////////////////////////////////////////////////////////
	// Output checks sampled mid cycle

	task automatic check_beat();
		logic [7:0] want;
		check_count++;
		if (!(rx_strb inside {4'b0001, 4'b0011, 4'b0111, 4'b1111})) begin
			error_count++;
			$display("[ERROR] %0t: rx_strb %04b is not a run of low bits", $time, rx_strb);
		end
		for (int i = 0; i < 4; i++) begin
			if (rx_strb[i]) begin
				if (exp_bytes.size() == 0) begin
					error_count++;
					$display("Data byte at %0t while no frame data is expected", $time);
				end else begin
					want = exp_bytes.pop_front();
					if (rx_data[8*i +: 8] != want) begin
						error_count++;
						$display("[ERROR] %0t: byte lane %0d got %02h expected %02h",
							$time, i, rx_data[8*i +: 8], want);
					end
				end
				frame_bytes++;
			end
		end
	endtask

	task automatic check_close();
		logic want_err;
		int want_cnt;
		check_count++;
		if (exp_err.size() == 0) begin
			error_count++;
			$display("Frame close at %0t while no frame is open", $time);
		end else begin
			want_err = exp_err.pop_front();
			want_cnt = exp_cnt.pop_front();
			if (rx_error != want_err) begin
				error_count++;
				$display("[ERROR] %0t: rx_error got %0b expected %0b", $time, rx_error, want_err);
			end
			if (frame_bytes != want_cnt) begin
				error_count++;
				$display("[ERROR] %0t: frame had %0d bytes expected %0d",
					$time, frame_bytes, want_cnt);
			end
		end
		frame_bytes = 0;
	endtask

	always @(posedge xgmii_rx_clk) begin
		cycle_count++;
	end

	always @(negedge xgmii_rx_clk) begin
		if (rst_n !== 1'b1) begin
			check_count++;
			if (rx_valid !== 1'b0 || rx_last !== 1'b0 || rx_error !== 1'b0) begin
				error_count++;
				$display("[ERROR] %0t: outputs active during reset", $time);
			end
		end else if ($isunknown({rx_valid, rx_last, rx_error})) begin
			error_count++;
			$display("Unknown level on rx_valid, rx_last or rx_error at %0t", $time);
		end else begin
			if (rx_valid) begin
				check_beat();
			end
			if (rx_last) begin
				check_close();
			end else if (rx_error) begin
				error_count++;
				$display("rx_error high without rx_last at %0t", $time);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus

	// Stall cycles carry random junk that must be ignored
	task automatic send_word(input logic [31:0] d, input logic [3:0] c);
		logic [31:0] r;
		while (stall_en && take_bits(3) == 0) begin
			r = take_bits(4);
			@(posedge xgmii_rx_clk);
			xgmii_rxd.word <= take_bits(32);
			xgmii_rxc <= r[3:0];
			xgmii_rx_valid <= 1'b0;
		end
		@(posedge xgmii_rx_clk);
		xgmii_rxd.word <= d;
		xgmii_rxc <= c;
		xgmii_rx_valid <= 1'b1;
	endtask

	// Idle, or an all-control junk word that never starts a frame
	task automatic send_gap_word();
		logic [31:0] r;
		logic [31:0] d;
		d = {4{XGMII_CTL_IDLE}};
		if (junk_en) begin
			for (int i = 0; i < 4; i++) begin
				r = take_bits(2);
				case (r[1:0])
					2'd0: d[8*i +: 8] = XGMII_CTL_IDLE;
					2'd1: d[8*i +: 8] = XGMII_CTL_END;
					2'd2: d[8*i +: 8] = XGMII_CTL_ERROR;
					default: begin
						r = take_bits(8);
						d[8*i +: 8] = r[7:0];
					end
				endcase
			end
			if (d[31:24] == XGMII_CTL_START) begin
				d[31:24] = XGMII_CTL_IDLE;
			end
		end
		send_word(d, 4'b1111);
	endtask

	task automatic send_frame(input int kind, input int len);
		logic [7:0] body[$];
		logic ctl_q[$];
		logic [31:0] fcs;
		logic [31:0] r;
		logic [31:0] w;
		logic [3:0] c;
		int words;
		int hit;
		payload.delete();
		for (int i = 0; i < len; i++) begin
			r = take_bits(8);
			payload.push_back(r[7:0]);
		end
		fcs = payload_fcs();
		if (kind == KIND_BAD_FCS) begin
			r = take_bits(5);
			fcs[r[4:0]] = ~fcs[r[4:0]];
		end

		// Payload, FCS low byte first, terminate, idle fill
		body = payload;
		for (int i = 0; i < 4; i++) begin
			body.push_back(fcs[8*i +: 8]);
		end
		foreach (body[i]) begin
			ctl_q.push_back(1'b0);
		end
		body.push_back(XGMII_CTL_END);
		ctl_q.push_back(1'b1);
		while (body.size() % 4 != 0) begin
			body.push_back(XGMII_CTL_IDLE);
			ctl_q.push_back(1'b1);
		end
		words = body.size() / 4;

		// What the MAC should hand out for this frame
		if (kind == KIND_GOOD || kind == KIND_BAD_FCS) begin
			foreach (payload[i]) begin
				exp_bytes.push_back(payload[i]);
			end
			exp_err.push_back(kind == KIND_BAD_FCS);
			exp_cnt.push_back(len);
		end else if (kind == KIND_ABORT) begin
			// Error lands before the terminate word
			// Full words ahead of it pass
			r = take_bits(6);
			hit = r[3:0] % (words - 1);
			body[4*hit + r[5:4]] = XGMII_CTL_ERROR;
			ctl_q[4*hit + r[5:4]] = 1'b1;
			for (int i = 0; i < 4*hit; i++) begin
				exp_bytes.push_back(body[i]);
			end
			exp_err.push_back(1'b1);
			exp_cnt.push_back(4*hit);
		end

		send_word({XGMII_CTL_START, 24'h55_5555}, 4'b1000);
		w = PREAMBLE_SFD_WORD;
		c = 4'b0000;
		if (kind == KIND_BAD_PRE) begin
			r = take_bits(6);
			if (r[5]) begin
				c[r[1:0]] = 1'b1;
			end else begin
				w[r[4:0]] = ~w[r[4:0]];
			end
		end
		send_word(w, c);
		for (int k = 0; k < words; k++) begin
			w = {body[4*k], body[4*k+1], body[4*k+2], body[4*k+3]};
			c = {ctl_q[4*k], ctl_q[4*k+1], ctl_q[4*k+2], ctl_q[4*k+3]};
			send_word(w, c);
		end

		// Inter-frame gap of 3 to 6 words
		r = take_bits(2);
		for (int g = 0; g < 3 + r[1:0]; g++) begin
			send_gap_word();
		end
	endtask

	task automatic run_test(input string name, input int frames, input int kind,
		input bit stalls, input bit junk);
		logic [31:0] r;
		int checks0;
		int errors0;
		int len;
		int k;
		checks0 = check_count;
		errors0 = error_count;
		stall_en = stalls;
		junk_en = junk;
		for (int f = 0; f < frames; f++) begin
			r = take_bits(6);
			len = 1 + r[5:0] % 40;
			k = kind;
			// Step through all four terminate lanes
			if (kind == KIND_GOOD) begin
				len = 1 + 4 * (r[5:0] % 10) + f % 4;
			end
			if (kind == KIND_MIX) begin
				k = take_bits(1);
			end
			send_frame(k, len);
		end
		// Idle until every open frame has closed
		while (exp_err.size() != 0 || exp_bytes.size() != 0) begin
			send_gap_word();
		end
		repeat (3) send_gap_word();
		$display("test %-13s %0d frames, %0d checks, %0d errors",
			name, frames, check_count - checks0, error_count - errors0);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		// A frame is already on the wire while reset is held
		rst_n = 1'b0;
		xgmii_rxd.word = {XGMII_CTL_START, 24'h55_5555};
		xgmii_rxc = 4'b1000;
		xgmii_rx_valid = 1'b1;
		@(posedge xgmii_rx_clk);
		xgmii_rxd.word <= PREAMBLE_SFD_WORD;
		xgmii_rxc <= 4'b0000;
		@(posedge xgmii_rx_clk);
		rst_n <= 1'b1;
		// Rest of that frame must not come out once reset lifts
		send_word(32'h0102_0304, 4'b0000);
		send_word(32'h0506_0708, 4'b0000);
		send_word({XGMII_CTL_END, {3{XGMII_CTL_IDLE}}}, 4'b1111);
		repeat (4) send_gap_word();
		$display("test %-13s %0d checks, %0d errors", "reset", check_count, error_count);

		run_test("good", 16, KIND_GOOD, 1'b0, 1'b0);
		run_test("bad_fcs", 8, KIND_BAD_FCS, 1'b0, 1'b0);
		run_test("bad_preamble", 8, KIND_BAD_PRE, 1'b0, 1'b1);
		run_test("abort", 8, KIND_ABORT, 1'b0, 1'b0);
		run_test("stalls", 24, KIND_MIX, 1'b1, 1'b0);

		$display("total %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// Hard stop if a frame never closes
	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Timeout after %0d cycles with %0d bytes and %0d frame closes still expected",
			cycle_count, exp_bytes.size(), exp_err.size());
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/crc32_eth_x32_var.sv ====
`timescale 1ns/1ns
`default_nettype none

module crc32_eth_x32_var(
	input wire xgmii_rx_clk,
	input wire rst_n,
	input wire ce,
	input wire reset,
	input wire [31:0] din,
	input wire [2:0] din_len,
	output logic [31:0] crc_out
);

	import xgmii_rx_pkg::*;

	////////////////////////////////////////////////////////////
	// Byte-serial update

	// Folds the first len bytes of data into crc
	// First byte sits in bits 31:24, each byte goes in LSB first
	function automatic logic [31:0] crc_update(
		input logic [31:0] crc,
		input logic [31:0] data,
		input logic [2:0] len
	);
		logic [31:0] c;
		logic [7:0] b;
		c = crc;
		for (int i = 0; i < 4; i++) begin
			if (i < len) begin
				b = data[31 - 8*i -: 8];
				for (int j = 0; j < 8; j++) begin
					if (c[0] ^ b[j]) begin
						c = (c >> 1) ^ CRC_POLY;
					end else begin
						c = c >> 1;
					end
				end
			end
		end
		return c;
	endfunction

	////////////////////////////////////////////////////////////
	// Stage 1 input register

	logic ce_q;
	logic reset_q;
	logic [31:0] din_q;
	logic [2:0] len_q;

	// Control flags
	always_ff @(posedge xgmii_rx_clk) begin
		if (!rst_n) begin
			ce_q <= 1'b0;
			reset_q <= 1'b0;
		end else begin
			ce_q <= ce;
			reset_q <= reset;
		end
	end

	// Data and length only matter alongside ce_q
	always_ff @(posedge xgmii_rx_clk) begin
		din_q <= din;
		len_q <= din_len;
	end

	////////////////////////////////////////////////////////////
	// Stage 2 running remainder

	logic [31:0] crc_state;
	logic [31:0] crc_final;

	// Reset and ce travel through the same stage so their order holds
	always_ff @(posedge xgmii_rx_clk) begin
		if (!rst_n) begin
			crc_state <= 32'hffff_ffff;
		end else if (reset_q) begin
			crc_state <= 32'hffff_ffff;
		end else if (ce_q) begin
			crc_state <= crc_update(crc_state, din_q, len_q);
		end
	end

	// Final inversion
	assign crc_final = ~crc_state;

	// FCS goes out low byte first
	// Swap so the first wire byte lands at the top
	assign crc_out = {crc_final[7:0], crc_final[15:8], crc_final[23:16], crc_final[31:24]};

	////////////////////////////////////////////////////////////
	// Checks

	// At most one full word per beat
	assert property (@(posedge xgmii_rx_clk) disable iff (!rst_n)
		ce |-> (din_len <= 3'd4))
		else $error("crc32: din_len %0d out of range", din_len);

endmodule

`default_nettype wire

// ==== source/fcs_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module fcs_checker(
	input wire xgmii_rx_clk,
	input wire rst_n,
	input wire beat,
	input wire [31:0] fcs_expected,
	input wire fcs_pending,
	input wire frame_abort,
	input wire [31:0] crc_out,
	output logic rx_last,
	output logic rx_error
);

	import xgmii_rx_pkg::*;

	////////////////////////////////////////////////////////////
	// Wait out the CRC latency

	logic [CRC_LATENCY-1:0] pend;
	logic [CRC_LATENCY-1:0][31:0] fcs_pipe;

	// Expected FCS follows its pending flag
	// Stalled cycles do not advance either one
	always_ff @(posedge xgmii_rx_clk) begin
		if (beat) begin
			fcs_pipe <= {fcs_pipe[CRC_LATENCY-2:0], fcs_expected};
		end
	end

	////////////////////////////////////////////////////////////
	// Frame close

	always_ff @(posedge xgmii_rx_clk) begin
		if (!rst_n) begin
			pend <= '0;
			rx_last <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			rx_last <= 1'b0;
			rx_error <= 1'b0;

			if (frame_abort) begin
				// Aborted frame closes at once, flagged bad
				// Any check still in flight is dropped
				rx_last <= 1'b1;
				rx_error <= 1'b1;
				pend <= '0;
			end else if (beat) begin
				pend <= {pend[CRC_LATENCY-2:0], fcs_pending};

				// CRC has settled by the time the flag leaves the pipe
				if (pend[CRC_LATENCY-1]) begin
					rx_last <= 1'b1;
					rx_error <= (crc_out != fcs_pipe[CRC_LATENCY-1]);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Checks

	// Error is only meaningful on the closing beat
	assert property (@(posedge xgmii_rx_clk) disable iff (!rst_n)
		rx_error |-> rx_last)
		else $error("fcs_checker: rx_error without rx_last");

endmodule

`default_nettype wire

// ==== source/rx_framer.sv ====
`timescale 1ns/1ns
`default_nettype none

module rx_framer(
	input wire xgmii_rx_clk,
	input wire rst_n,
	input wire xgmii_rx_pkg::xgmii_word_u xgmii_rxd,
	input wire [3:0] xgmii_rxc,
	input wire xgmii_rx_valid,
	output logic [31:0] rx_data,
	output logic rx_valid,
	output logic [3:0] rx_strb,
	output logic [31:0] crc_din,
	output logic [2:0] crc_len,
	output logic crc_reset,
	output logic [31:0] fcs_expected,
	output logic fcs_pending,
	output logic frame_abort,
	output logic beat
);

	import xgmii_rx_pkg::*;

	////////////////////////////////////////////////////////////
	// Lane decoding

	logic [XGMII_LANES-1:0] lane_end;
	logic [XGMII_LANES-1:0] lane_err;
	logic lane_start;

	// Terminate and error may show up in any lane
	always_comb begin
		for (int i = 0; i < XGMII_LANES; i++) begin
			lane_end[i] = xgmii_rxc[i] && (xgmii_rxd.lane[i] == XGMII_CTL_END);
			lane_err[i] = xgmii_rxc[i] && (xgmii_rxd.lane[i] == XGMII_CTL_ERROR);
		end
	end

	// Start is only recognised in the leftmost lane
	assign lane_start = xgmii_rxc[3] && (xgmii_rxd.lane[3] == XGMII_CTL_START);

	////////////////////////////////////////////////////////////
	// Held word

	logic [1:0] state;
	logic last_was_preamble;

	// Each accepted word waits here until the next one shows
	// whether it is payload or FCS
	// Byte order flips so the first wire byte lands in bits 7:0
	always_ff @(posedge xgmii_rx_clk) begin
		if (xgmii_rx_valid) begin
			rx_data <= {xgmii_rxd.lane[0], xgmii_rxd.lane[1],
				xgmii_rxd.lane[2], xgmii_rxd.lane[3]};
		end
	end

	// Back to wire order for the CRC engine
	assign crc_din = {rx_data[7:0], rx_data[15:8], rx_data[23:16], rx_data[31:24]};

	////////////////////////////////////////////////////////////
	// End lane decode

	logic [3:0] end_strb;
	logic [2:0] end_len;
	logic [31:0] fcs_next;

	// First terminate wins
	// Anything before the last four bytes is data, the rest is FCS
	always_comb begin
		end_strb = 4'b1111;
		end_len = 3'd4;
		fcs_next = crc_din;
		if (lane_end[3]) begin
			// Whole held word is FCS
			end_strb = 4'b0000;
			end_len = 3'd0;
		end else if (lane_end[2]) begin
			end_strb = 4'b0001;
			end_len = 3'd1;
			fcs_next = {crc_din[23:0], xgmii_rxd.lane[3]};
		end else if (lane_end[1]) begin
			end_strb = 4'b0011;
			end_len = 3'd2;
			fcs_next = {crc_din[15:0], xgmii_rxd.lane[3], xgmii_rxd.lane[2]};
		end else if (lane_end[0]) begin
			end_strb = 4'b0111;
			end_len = 3'd3;
			fcs_next = {crc_din[7:0], xgmii_rxd.lane[3], xgmii_rxd.lane[2],
				xgmii_rxd.lane[1]};
		end
	end

	////////////////////////////////////////////////////////////
	// Output strobes

	logic body_beat;

	// Held word is payload only inside the body
	// The word right after the SFD has no predecessor to release
	assign body_beat = xgmii_rx_valid && (state == RX_BODY) && !last_was_preamble;

	// Nothing goes out when the held word is all FCS
	assign rx_valid = body_beat && !lane_end[3];
	assign rx_strb = body_beat ? end_strb : 4'b0000;
	assign crc_len = rx_valid ? end_len : 3'd0;

	// Restart the remainder while the SFD word goes by
	assign crc_reset = xgmii_rx_valid && (state == RX_PREAMBLE);

	////////////////////////////////////////////////////////////
	// Receive FSM

	always_ff @(posedge xgmii_rx_clk) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			last_was_preamble <= 1'b0;
			beat <= 1'b0;
			fcs_pending <= 1'b0;
			frame_abort <= 1'b0;
		end else begin
			beat <= xgmii_rx_valid;
			fcs_pending <= 1'b0;
			frame_abort <= 1'b0;

			// Stalled words leave everything as is
			if (xgmii_rx_valid) begin
				last_was_preamble <= (state == RX_PREAMBLE);

				case (state)
					// Idles, junk and stray errors are ignored here
					RX_IDLE: begin
						if (lane_start) begin
							state <= RX_PREAMBLE;
						end
					end

					// Exactly one SFD word with no control flags
					RX_PREAMBLE: begin
						if ((xgmii_rxc != 4'b0000) || (xgmii_rxd.word != PREAMBLE_SFD_WORD)) begin
							state <= RX_IDLE;
						end else begin
							state <= RX_BODY;
						end
					end

					// Terminate may sit in any lane
					RX_BODY: begin
						if (|lane_end) begin
							state <= RX_IDLE;
							fcs_pending <= 1'b1;
						end
					end

					default: begin
						state <= RX_IDLE;
					end
				endcase

				// Error inside a frame drops it
				// Overrides the terminate handling above
				if ((|lane_err) && (state != RX_IDLE)) begin
					state <= RX_IDLE;
					fcs_pending <= 1'b0;
					frame_abort <= 1'b1;
				end
			end
		end
	end

	// Keeps the last four bytes seen in the body
	// Only the value captured on the terminate word gets checked
	always_ff @(posedge xgmii_rx_clk) begin
		if (xgmii_rx_valid && (state == RX_BODY)) begin
			fcs_expected <= fcs_next;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks

	assert property (@(posedge xgmii_rx_clk) disable iff (!rst_n)
		(rx_strb != 4'b0000) |-> rx_valid)
		else $error("rx_framer: strobes without valid");

	assert property (@(posedge xgmii_rx_clk) disable iff (!rst_n)
		state != 2'd3)
		else $error("rx_framer: illegal state code");

endmodule

`default_nettype wire

// ==== source/xgmii_rx_mac.sv ====
`timescale 1ns/1ns
`default_nettype none

module xgmii_rx_mac(
	input wire xgmii_rx_clk,
	input wire rst_n,
	input wire xgmii_rx_pkg::xgmii_word_u xgmii_rxd,
	input wire [3:0] xgmii_rxc,
	input wire xgmii_rx_valid,
	output logic [31:0] rx_data,
	output logic rx_valid,
	output logic [3:0] rx_strb,
	output logic rx_last,
	output logic rx_error
);

	////////////////////////////////////////////////////////////
	// Internal nets

	// Framer to CRC
	logic [31:0] crc_din;
	logic [2:0] crc_len;
	logic crc_reset;

	// CRC to checker
	logic [31:0] crc_out;

	// Framer to checker
	logic [31:0] fcs_expected;
	logic fcs_pending;
	logic frame_abort;
	logic beat;

	////////////////////////////////////////////////////////////
	// Lane decode, FSM and word lag

	rx_framer u_framer(
		.xgmii_rx_clk(xgmii_rx_clk),
		.rst_n(rst_n),
		.xgmii_rxd(xgmii_rxd),
		.xgmii_rxc(xgmii_rxc),
		.xgmii_rx_valid(xgmii_rx_valid),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_strb(rx_strb),
		.crc_din(crc_din),
		.crc_len(crc_len),
		.crc_reset(crc_reset),
		.fcs_expected(fcs_expected),
		.fcs_pending(fcs_pending),
		.frame_abort(frame_abort),
		.beat(beat)
	);

	////////////////////////////////////////////////////////////
	// CRC over every forwarded byte

	crc32_eth_x32_var u_crc(
		.xgmii_rx_clk(xgmii_rx_clk),
		.rst_n(rst_n),
		.ce(rx_valid),
		.reset(crc_reset),
		.din(crc_din),
		.din_len(crc_len),
		.crc_out(crc_out)
	);

	////////////////////////////////////////////////////////////
	// FCS compare and frame close

	fcs_checker u_checker(
		.xgmii_rx_clk(xgmii_rx_clk),
		.rst_n(rst_n),
		.beat(beat),
		.fcs_expected(fcs_expected),
		.fcs_pending(fcs_pending),
		.frame_abort(frame_abort),
		.crc_out(crc_out),
		.rx_last(rx_last),
		.rx_error(rx_error)
	);

endmodule

`default_nettype wire

// ==== source/xgmii_rx_pkg.sv ====
`default_nettype none

package xgmii_rx_pkg;

	////////////////////////////////////////////////////////////
	// XGMII control characters

	// Start of frame, only legal in lane 3
	localparam logic [7:0] XGMII_CTL_START = 8'hfb;

	// Terminate, may land in any lane
	localparam logic [7:0] XGMII_CTL_END = 8'hfd;

	// In-band error from the PCS
	localparam logic [7:0] XGMII_CTL_ERROR = 8'hfe;

	// Inter-frame idle
	localparam logic [7:0] XGMII_CTL_IDLE = 8'h07;

	// Second word of the frame
	// Three preamble bytes then the SFD, lane 3 first
	localparam logic [31:0] PREAMBLE_SFD_WORD = 32'h5555_55d5;

	////////////////////////////////////////////////////////////
	// Bus geometry

	localparam int XGMII_LANES = 4;
	localparam int LANE_W = 8;

	////////////////////////////////////////////////////////////
	// Receive state codes

	localparam logic [1:0] RX_IDLE = 2'd0;
	localparam logic [1:0] RX_PREAMBLE = 2'd1;
	localparam logic [1:0] RX_BODY = 2'd2;

	////////////////////////////////////////////////////////////
	// CRC engine

	// Reflected form of the 802.3 polynomial
	localparam logic [31:0] CRC_POLY = 32'hedb8_8320;

	// Valid beats from ce to a settled crc_out
	localparam int CRC_LATENCY = 2;

	////////////////////////////////////////////////////////////
	// One XGMII data word

	// Whole word for the preamble compare
	// Per-lane bytes for control decoding, lane 3 is first on the wire
	typedef union packed {
		logic [31:0] word;
		logic [XGMII_LANES-1:0][LANE_W-1:0] lane;
	} xgmii_word_u;

endpackage

`default_nettype wire
